//--- hw/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath and register file geometry
`define DE_DBITS      32
`define DE_REGWORDS   32
`define DE_REGNOBITS  5
`define DE_INSTBITS   32

// major opcodes, inst[6:0]
`define DE_OP_REG     7'b0110011
`define DE_OP_IMM     7'b0010011
`define DE_OP_LUI     7'b0110111
`define DE_OP_AUIPC   7'b0010111
`define DE_OP_LOAD    7'b0000011
`define DE_OP_STORE   7'b0100011
`define DE_OP_JAL     7'b1101111
`define DE_OP_JALR    7'b1100111
`define DE_OP_BRANCH  7'b1100011

// funct3 codes
`define DE_F3_ADD     3'b000  // add, sub, addi
`define DE_F3_SLL     3'b001
`define DE_F3_SLT     3'b010
`define DE_F3_SLTU    3'b011
`define DE_F3_XOR     3'b100
`define DE_F3_SR      3'b101  // srl, sra and immediate forms
`define DE_F3_OR      3'b110
`define DE_F3_AND     3'b111
`define DE_F3_MUL     3'b000
`define DE_F3_LW      3'b010
`define DE_F3_SW      3'b010
`define DE_F3_JALR    3'b000
`define DE_F3_BEQ     3'b000
`define DE_F3_BNE     3'b001
`define DE_F3_BLT     3'b100
`define DE_F3_BGE     3'b101
`define DE_F3_BLTU    3'b110
`define DE_F3_BGEU    3'b111

// funct7 codes
`define DE_F7_BASE    7'b0000000
`define DE_F7_ALT     7'b0100000  // sub, sra, srai
`define DE_F7_MUL     7'b0000001

`endif

//--- hw/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

  ////////////////////////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]                 funct7;
    logic [`DE_REGNOBITS-1:0]   rs2;
    logic [`DE_REGNOBITS-1:0]   rs1;
    logic [2:0]                 funct3;
    logic [`DE_REGNOBITS-1:0]   rd;
    logic [6:0]                 opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0]                imm_11_0;
    logic [`DE_REGNOBITS-1:0]   rs1;
    logic [2:0]                 funct3;
    logic [`DE_REGNOBITS-1:0]   rd;
    logic [6:0]                 opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0]                 imm_11_5;
    logic [`DE_REGNOBITS-1:0]   rs2;
    logic [`DE_REGNOBITS-1:0]   rs1;
    logic [2:0]                 funct3;
    logic [4:0]                 imm_4_0;
    logic [6:0]                 opcode;
  } inst_s_t;

  typedef struct packed {
    logic                       imm_12;
    logic [5:0]                 imm_10_5;
    logic [`DE_REGNOBITS-1:0]   rs2;
    logic [`DE_REGNOBITS-1:0]   rs1;
    logic [2:0]                 funct3;
    logic [3:0]                 imm_4_1;
    logic                       imm_11;
    logic [6:0]                 opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0]                imm_31_12;
    logic [`DE_REGNOBITS-1:0]   rd;
    logic [6:0]                 opcode;
  } inst_ux_t;

  typedef struct packed {
    logic                       imm_20;
    logic [9:0]                 imm_10_1;
    logic                       imm_11;
    logic [7:0]                 imm_19_12;
    logic [`DE_REGNOBITS-1:0]   rd;
    logic [6:0]                 opcode;
  } inst_j_t;

  // one 32 bit word, read per format
  typedef union packed {
    inst_r_t  r;
    inst_i_t  i;
    inst_s_t  s;
    inst_b_t  b;
    inst_ux_t u;
    inst_j_t  j;
  } inst_u;

  ////////////////////////////////////////////////////////////
  // decode results
  ////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    iop_add, iop_sub, iop_and, iop_or, iop_xor, iop_slt, iop_sltu,
    iop_sra, iop_srl, iop_sll, iop_mul,
    iop_addi, iop_andi, iop_ori, iop_xori, iop_slti, iop_sltiu,
    iop_srai, iop_srli, iop_slli,
    iop_lui, iop_auipc, iop_lw, iop_sw, iop_jal, iop_jalr,
    iop_beq, iop_bne, iop_blt, iop_bge, iop_bltu, iop_bgeu,
    iop_invalid
  } iop_e;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_kind_e;

  typedef struct packed {
    logic is_br;    // conditional branch
    logic is_jmp;   // jal / jalr
    logic rd_mem;   // load
    logic wr_mem;   // store
    logic wr_reg;   // writes a nonzero rd
    logic use_rs1;
    logic use_rs2;
  } ctrl_t;

  ////////////////////////////////////////////////////////////
  // stage boundaries
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   valid;
    inst_u                  inst;
    logic [`DE_DBITS-1:0]   pc;
    logic [`DE_DBITS-1:0]   pc_plus4;
  } fetch_pkt_t;

  typedef struct packed {
    logic                       wr_reg;
    logic [`DE_REGNOBITS-1:0]   wregno;
    logic [`DE_DBITS-1:0]       regval;
  } wb_pkt_t;

  typedef struct packed {
    logic                       valid;
    logic [`DE_INSTBITS-1:0]    inst;
    logic [`DE_DBITS-1:0]       pc;
    logic [`DE_DBITS-1:0]       pc_plus4;
    iop_e                       op;
    logic [`DE_DBITS-1:0]       rs1_val;
    logic [`DE_DBITS-1:0]       rs2_val;
    logic [`DE_DBITS-1:0]       imm;
    logic                       is_br;
    logic                       is_jmp;
    logic                       rd_mem;
    logic                       wr_mem;
    logic                       wr_reg;
    logic [`DE_REGNOBITS-1:0]   rd;
  } de_latch_t;

endpackage

//--- hw/inst_decoder.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module inst_decoder (
  input  decode_pkg::inst_u     inst,
  output decode_pkg::iop_e      op,
  output decode_pkg::imm_kind_e imm_kind,
  output decode_pkg::ctrl_t     ctrl
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       writes_rd;  // opcode class has a destination

  // shift immediates reuse the funct7 slot, so the r view serves every format here
  assign opcode = inst.r.opcode;
  assign f3     = inst.r.funct3;
  assign f7     = inst.r.funct7;

  ////////////////////////////////////////////////////////////
  // internal opcode
  ////////////////////////////////////////////////////////////

  always_comb begin
    op = decode_pkg::iop_invalid;
    case (opcode)
      `DE_OP_REG: begin
        case ({f7, f3})
          {`DE_F7_BASE, `DE_F3_ADD}:  op = decode_pkg::iop_add;
          {`DE_F7_ALT,  `DE_F3_ADD}:  op = decode_pkg::iop_sub;
          {`DE_F7_BASE, `DE_F3_AND}:  op = decode_pkg::iop_and;
          {`DE_F7_BASE, `DE_F3_OR}:   op = decode_pkg::iop_or;
          {`DE_F7_BASE, `DE_F3_XOR}:  op = decode_pkg::iop_xor;
          {`DE_F7_BASE, `DE_F3_SLT}:  op = decode_pkg::iop_slt;
          {`DE_F7_BASE, `DE_F3_SLTU}: op = decode_pkg::iop_sltu;
          {`DE_F7_ALT,  `DE_F3_SR}:   op = decode_pkg::iop_sra;
          {`DE_F7_BASE, `DE_F3_SR}:   op = decode_pkg::iop_srl;
          {`DE_F7_BASE, `DE_F3_SLL}:  op = decode_pkg::iop_sll;
          {`DE_F7_MUL,  `DE_F3_MUL}:  op = decode_pkg::iop_mul;
          default: ;
        endcase
      end
      `DE_OP_IMM: begin
        case (f3)
          `DE_F3_ADD:  op = decode_pkg::iop_addi;
          `DE_F3_AND:  op = decode_pkg::iop_andi;
          `DE_F3_OR:   op = decode_pkg::iop_ori;
          `DE_F3_XOR:  op = decode_pkg::iop_xori;
          `DE_F3_SLT:  op = decode_pkg::iop_slti;
          `DE_F3_SLTU: op = decode_pkg::iop_sltiu;
          `DE_F3_SLL: begin
            if (f7 == `DE_F7_BASE) op = decode_pkg::iop_slli;
          end
          `DE_F3_SR: begin
            if (f7 == `DE_F7_BASE)
              op = decode_pkg::iop_srli;
            else if (f7 == `DE_F7_ALT)
              op = decode_pkg::iop_srai;
          end
          default: ;
        endcase
      end
      `DE_OP_LUI:   op = decode_pkg::iop_lui;
      `DE_OP_AUIPC: op = decode_pkg::iop_auipc;
      `DE_OP_JAL:   op = decode_pkg::iop_jal;
      `DE_OP_LOAD: begin
        if (f3 == `DE_F3_LW) op = decode_pkg::iop_lw;
      end
      `DE_OP_STORE: begin
        if (f3 == `DE_F3_SW) op = decode_pkg::iop_sw;
      end
      `DE_OP_JALR: begin
        if (f3 == `DE_F3_JALR) op = decode_pkg::iop_jalr;
      end
      `DE_OP_BRANCH: begin
        case (f3)
          `DE_F3_BEQ:  op = decode_pkg::iop_beq;
          `DE_F3_BNE:  op = decode_pkg::iop_bne;
          `DE_F3_BLT:  op = decode_pkg::iop_blt;
          `DE_F3_BGE:  op = decode_pkg::iop_bge;
          `DE_F3_BLTU: op = decode_pkg::iop_bltu;
          `DE_F3_BGEU: op = decode_pkg::iop_bgeu;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // format, operand use and control flags per class
  ////////////////////////////////////////////////////////////

  always_comb begin
    imm_kind  = decode_pkg::imm_none;
    ctrl      = '0;
    writes_rd = 1'b0;
    case (op)
      decode_pkg::iop_add, decode_pkg::iop_sub, decode_pkg::iop_and,
      decode_pkg::iop_or, decode_pkg::iop_xor, decode_pkg::iop_slt,
      decode_pkg::iop_sltu, decode_pkg::iop_sra, decode_pkg::iop_srl,
      decode_pkg::iop_sll, decode_pkg::iop_mul: begin
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
        writes_rd    = 1'b1;
      end
      decode_pkg::iop_addi, decode_pkg::iop_andi, decode_pkg::iop_ori,
      decode_pkg::iop_xori, decode_pkg::iop_slti, decode_pkg::iop_sltiu,
      decode_pkg::iop_srai, decode_pkg::iop_srli, decode_pkg::iop_slli: begin
        imm_kind     = decode_pkg::imm_i;
        ctrl.use_rs1 = 1'b1;
        writes_rd    = 1'b1;
      end
      decode_pkg::iop_lw: begin
        imm_kind     = decode_pkg::imm_i;
        ctrl.use_rs1 = 1'b1;
        ctrl.rd_mem  = 1'b1;
        writes_rd    = 1'b1;
      end
      decode_pkg::iop_jalr: begin
        imm_kind     = decode_pkg::imm_i;
        ctrl.use_rs1 = 1'b1;
        ctrl.is_jmp  = 1'b1;
        writes_rd    = 1'b1;
      end
      decode_pkg::iop_lui, decode_pkg::iop_auipc: begin
        imm_kind  = decode_pkg::imm_u;
        writes_rd = 1'b1;
      end
      decode_pkg::iop_jal: begin
        imm_kind    = decode_pkg::imm_j;
        ctrl.is_jmp = 1'b1;
        writes_rd   = 1'b1;
      end
      decode_pkg::iop_sw: begin
        imm_kind     = decode_pkg::imm_s;
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
        ctrl.wr_mem  = 1'b1;
      end
      decode_pkg::iop_beq, decode_pkg::iop_bne, decode_pkg::iop_blt,
      decode_pkg::iop_bge, decode_pkg::iop_bltu, decode_pkg::iop_bgeu: begin
        imm_kind     = decode_pkg::imm_b;
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
        ctrl.is_br   = 1'b1;
      end
      default: ;  // invalid leaves every flag low
    endcase
    ctrl.wr_reg = writes_rd && (inst.r.rd != '0);  // x0 writes are dropped
  end

endmodule

//--- hw/imm_gen.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module imm_gen (
  input  decode_pkg::inst_u     inst,
  input  decode_pkg::imm_kind_e imm_kind,
  output logic [`DE_DBITS-1:0]  imm
);

  // every format keeps its sign in inst[31]
  always_comb begin
    case (imm_kind)
      decode_pkg::imm_i:
        imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
      decode_pkg::imm_s:
        imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      decode_pkg::imm_b:
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};  // halfword aligned
      decode_pkg::imm_u:
        imm = {inst.u.imm_31_12, 12'b0};
      decode_pkg::imm_j:
        imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
      default:
        imm = '0;  // no immediate
    endcase
  end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      reset,
  input  decode_pkg::wb_pkt_t       wb,
  input  logic [`DE_REGNOBITS-1:0]  rs1,
  input  logic [`DE_REGNOBITS-1:0]  rs2,
  output logic [`DE_DBITS-1:0]      rs1_val,
  output logic [`DE_DBITS-1:0]      rs2_val
);

  logic [`DE_DBITS-1:0] regs [`DE_REGWORDS];

  // a same-cycle writeback overrides the stored value
  function automatic logic [`DE_DBITS-1:0] read_port(input logic [`DE_REGNOBITS-1:0] idx);
    if (wb.wr_reg && (wb.wregno != '0) && (wb.wregno == idx))
      return wb.regval;
    return regs[idx];
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `DE_REGWORDS; i++)
        regs[i] <= '0;
    end else if (wb.wr_reg && (wb.wregno != '0)) begin
      regs[wb.wregno] <= wb.regval;  // x0 stays zero
    end
  end

  always_comb begin
    rs1_val = read_port(rs1);
    rs2_val = read_port(rs2);
  end

  // x0 is hardwired through reset and the write guard
  a_x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    ((rs1 == '0) |-> (rs1_val == '0)) and ((rs2 == '0) |-> (rs2_val == '0)));

endmodule

//--- hw/hazard_scoreboard.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module hazard_scoreboard (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      valid,
  input  decode_pkg::ctrl_t         ctrl,
  input  logic [`DE_REGNOBITS-1:0]  rs1,
  input  logic [`DE_REGNOBITS-1:0]  rs2,
  input  logic [`DE_REGNOBITS-1:0]  rd,
  input  decode_pkg::wb_pkt_t       wb,
  input  logic                      br_mispred,
  output logic                      stall
);

  logic [`DE_REGWORDS-1:0] pending;  // one bit per register with a write in flight
  logic                    rs1_busy;
  logic                    rs2_busy;

  // a source written back this cycle is served by the register file bypass
  assign rs1_busy = pending[rs1] && !(wb.wr_reg && (wb.wregno == rs1));
  assign rs2_busy = pending[rs2] && !(wb.wr_reg && (wb.wregno == rs2));

  assign stall = br_mispred ||
                 (valid && ((ctrl.use_rs1 && rs1_busy) || (ctrl.use_rs2 && rs2_busy)));

  ////////////////////////////////////////////////////////////
  // pending bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (valid && !stall && ctrl.wr_reg)
        pending[rd] <= 1'b1;   // issue
      if (wb.wr_reg)
        pending[wb.wregno] <= 1'b0;  // later assignment, so clear wins
    end
  end

  // every writeback belongs to an instruction issued earlier
  a_wb_clears_pending: assert property (@(posedge clk) disable iff (reset)
    wb.wr_reg |-> pending[wb.wregno]);

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  decode_pkg::fetch_pkt_t  fe,
  input  decode_pkg::wb_pkt_t     wb,
  input  logic                    br_mispred,
  output logic                    stall,
  output decode_pkg::de_latch_t   de_out
);

  decode_pkg::iop_e       op;
  decode_pkg::imm_kind_e  imm_kind;
  decode_pkg::ctrl_t      ctrl;
  logic [`DE_DBITS-1:0]   rs1_val;
  logic [`DE_DBITS-1:0]   rs2_val;
  logic [`DE_DBITS-1:0]   imm;
  decode_pkg::de_latch_t  de_next;  // latch contents for this cycle

  ////////////////////////////////////////////////////////////
  // decode datapath
  ////////////////////////////////////////////////////////////

  inst_decoder u_inst_decoder (
    .inst     (fe.inst),
    .op       (op),
    .imm_kind (imm_kind),
    .ctrl     (ctrl)
  );

  imm_gen u_imm_gen (
    .inst     (fe.inst),
    .imm_kind (imm_kind),
    .imm      (imm)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .wb       (wb),
    .rs1      (fe.inst.r.rs1),
    .rs2      (fe.inst.r.rs2),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val)
  );

  hazard_scoreboard u_hazard_scoreboard (
    .clk        (clk),
    .reset      (reset),
    .valid      (fe.valid),
    .ctrl       (ctrl),
    .rs1        (fe.inst.r.rs1),
    .rs2        (fe.inst.r.rs2),
    .rd         (fe.inst.r.rd),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall)
  );

  ////////////////////////////////////////////////////////////
  // decode latch
  ////////////////////////////////////////////////////////////

  always_comb begin
    de_next.valid    = fe.valid;
    de_next.inst     = fe.inst;
    de_next.pc       = fe.pc;
    de_next.pc_plus4 = fe.pc_plus4;
    de_next.op       = op;
    de_next.rs1_val  = rs1_val;
    de_next.rs2_val  = rs2_val;
    de_next.imm      = imm;
    de_next.is_br    = ctrl.is_br;
    de_next.is_jmp   = ctrl.is_jmp;
    de_next.rd_mem   = ctrl.rd_mem;
    de_next.wr_mem   = ctrl.wr_mem;
    de_next.wr_reg   = ctrl.wr_reg;
    de_next.rd       = fe.inst.r.rd;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      de_out <= '0;
    else if (stall)
      de_out <= '0;  // bubble, fetch holds the instruction
    else
      de_out <= de_next;
  end

  // hazard or mispredict stall reaches execute as a bubble
  a_bubble_after_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> !de_out.valid);

endmodule

//--- sim/tb_decode_tasks.svh
`ifndef TB_DECODE_TASKS_SVH
`define TB_DECODE_TASKS_SVH

function logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, input logic [4:0] rs1,
                             input logic [2:0] f3, input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, `DE_OP_REG};
endfunction

function logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1, input logic [2:0] f3,
                             input logic [4:0] rd, input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                             input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, `DE_F3_SW, imm[4:0], `DE_OP_STORE};
endfunction

function logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, input logic [4:0] rs1,
                             input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `DE_OP_BRANCH};
endfunction

function logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `DE_OP_JAL};
endfunction

function logic [31:0] sext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

function logic [31:0] sext13(input logic [12:0] v);
  return {{19{v[12]}}, v};
endfunction

function logic [31:0] sext21(input logic [20:0] v);
  return {{11{v[20]}}, v};
endfunction

// flags = {is_br, is_jmp, rd_mem, wr_mem, writes rd}, chk = {rs1, rs2} value checks
task automatic run_one(input logic [31:0] inst, input decode_pkg::iop_e exp_op,
                       input logic [31:0] exp_imm, input logic [4:0] flags,
                       input logic [1:0] chk);
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] exp_pc;
  logic        exp_wr;
  rs1    = inst[19:15];
  rs2    = inst[24:20];
  rd     = inst[11:7];
  exp_pc = pc;
  exp_wr = flags[0] && (rd != 5'd0);  // x0 is never a destination
  drive_fetch(inst);
  pc = pc + 32'd4;
  #1;
  compare("stall", 32'd0, 32'(stall));
  tick();
  fe.valid = 1'b0;
  compare("de_out.valid", 32'd1, 32'(de_out.valid));
  compare("de_out.inst", inst, de_out.inst);
  compare("de_out.pc", exp_pc, de_out.pc);
  compare("de_out.pc_plus4", exp_pc + 32'd4, de_out.pc_plus4);
  compare("de_out.op", 32'(exp_op), 32'(de_out.op));
  compare("de_out.imm", exp_imm, de_out.imm);
  compare("de_out.rd", 32'(rd), 32'(de_out.rd));
  if (chk[1])
    compare("de_out.rs1_val", reg_model[rs1], de_out.rs1_val);
  if (chk[0])
    compare("de_out.rs2_val", reg_model[rs2], de_out.rs2_val);
  compare("de_out.is_br", 32'(flags[4]), 32'(de_out.is_br));
  compare("de_out.is_jmp", 32'(flags[3]), 32'(de_out.is_jmp));
  compare("de_out.rd_mem", 32'(flags[2]), 32'(de_out.rd_mem));
  compare("de_out.wr_mem", 32'(flags[1]), 32'(de_out.wr_mem));
  compare("de_out.wr_reg", 32'(exp_wr), 32'(de_out.wr_reg));
  if (exp_wr)
    retire(rd, lfsr_bits(32));  // frees the scoreboard bit again
endtask

task automatic check_reset_state();
  compare("de_out.valid", 32'd0, 32'(de_out.valid));
  compare("stall", 32'd0, 32'(stall));
  run_one(r_type(`DE_F7_BASE, 5'd0, 5'd0, `DE_F3_ADD, 5'd0), decode_pkg::iop_add,
          32'd0, 5'b00001, 2'b11);
endtask

task automatic decode_alu_ops();
  logic [31:0] rnd;
  logic [11:0] imm12;
  logic [4:0]  shamt;
  for (int r = 1; r <= 4; r++) begin
    // addi issues first so that the writeback finds a pending bit
    drive_fetch(i_type(12'd0, 5'd0, `DE_F3_ADD, 5'(r), `DE_OP_IMM));
    tick();
    retire(5'(r), lfsr_bits(32));
  end
  run_one(r_type(`DE_F7_BASE, 5'd2, 5'd1, `DE_F3_ADD, 5'd10), decode_pkg::iop_add,
          32'd0, 5'b00001, 2'b11);
  run_one(r_type(`DE_F7_ALT, 5'd3, 5'd4, `DE_F3_ADD, 5'd11), decode_pkg::iop_sub,
          32'd0, 5'b00001, 2'b11);
  run_one(r_type(`DE_F7_MUL, 5'd3, 5'd1, `DE_F3_MUL, 5'd12), decode_pkg::iop_mul,
          32'd0, 5'b00001, 2'b11);
  run_one(r_type(`DE_F7_BASE, 5'd4, 5'd2, `DE_F3_SLL, 5'd13), decode_pkg::iop_sll,
          32'd0, 5'b00001, 2'b11);
  run_one(r_type(`DE_F7_ALT, 5'd1, 5'd3, `DE_F3_SR, 5'd14), decode_pkg::iop_sra,
          32'd0, 5'b00001, 2'b11);
  run_one(r_type(`DE_F7_BASE, 5'd2, 5'd1, `DE_F3_SLTU, 5'd15), decode_pkg::iop_sltu,
          32'd0, 5'b00001, 2'b11);
  run_one(r_type(`DE_F7_BASE, 5'd2, 5'd1, `DE_F3_XOR, 5'd0), decode_pkg::iop_xor,
          32'd0, 5'b00001, 2'b11);  // rd x0, no register write
  rnd   = lfsr_bits(12);
  imm12 = rnd[11:0];
  run_one(i_type(imm12, 5'd2, `DE_F3_ADD, 5'd16, `DE_OP_IMM), decode_pkg::iop_addi,
          sext12(imm12), 5'b00001, 2'b10);
  rnd   = lfsr_bits(5);
  shamt = rnd[4:0];
  run_one(i_type({`DE_F7_BASE, shamt}, 5'd1, `DE_F3_SLL, 5'd17, `DE_OP_IMM),
          decode_pkg::iop_slli, sext12({`DE_F7_BASE, shamt}), 5'b00001, 2'b10);
  run_one(i_type({`DE_F7_ALT, shamt}, 5'd4, `DE_F3_SR, 5'd18, `DE_OP_IMM),
          decode_pkg::iop_srai, sext12({`DE_F7_ALT, shamt}), 5'b00001, 2'b10);
  rnd   = lfsr_bits(12);
  imm12 = rnd[11:0];
  run_one(i_type(imm12, 5'd3, `DE_F3_AND, 5'd19, `DE_OP_IMM), decode_pkg::iop_andi,
          sext12(imm12), 5'b00001, 2'b10);
endtask

task automatic decode_imm_ctrl();
  logic [31:0] rnd;
  logic [11:0] imm12;
  logic [12:0] imm13;
  logic [20:0] imm21;
  rnd   = lfsr_bits(12);
  imm12 = rnd[11:0];
  run_one(s_type(imm12, 5'd2, 5'd1), decode_pkg::iop_sw, sext12(imm12), 5'b00010, 2'b11);
  run_one(i_type(imm12, 5'd3, `DE_F3_LW, 5'd24, `DE_OP_LOAD), decode_pkg::iop_lw,
          sext12(imm12), 5'b00101, 2'b10);
  rnd   = lfsr_bits(12);
  imm13 = {rnd[11:0], 1'b0};
  run_one(b_type(imm13, 5'd2, 5'd1, `DE_F3_BEQ), decode_pkg::iop_beq, sext13(imm13),
          5'b10000, 2'b11);
  rnd   = lfsr_bits(12);
  imm13 = {rnd[11:0], 1'b0};
  run_one(b_type(imm13, 5'd4, 5'd3, `DE_F3_BGEU), decode_pkg::iop_bgeu, sext13(imm13),
          5'b10000, 2'b11);
  rnd = lfsr_bits(20);
  run_one({rnd[19:0], 5'd20, `DE_OP_LUI}, decode_pkg::iop_lui, {rnd[19:0], 12'd0},
          5'b00001, 2'b00);
  rnd = lfsr_bits(20);
  run_one({rnd[19:0], 5'd21, `DE_OP_AUIPC}, decode_pkg::iop_auipc, {rnd[19:0], 12'd0},
          5'b00001, 2'b00);
  rnd   = lfsr_bits(20);
  imm21 = {rnd[19:0], 1'b0};
  run_one(j_type(imm21, 5'd22), decode_pkg::iop_jal, sext21(imm21), 5'b01001, 2'b00);
  rnd   = lfsr_bits(12);
  imm12 = rnd[11:0];
  run_one(i_type(imm12, 5'd2, `DE_F3_JALR, 5'd23, `DE_OP_JALR), decode_pkg::iop_jalr,
          sext12(imm12), 5'b01001, 2'b10);
  // opcode 1111111 belongs to no class
  rnd = lfsr_bits(25);
  run_one({rnd[24:0], 7'b1111111}, decode_pkg::iop_invalid, 32'd0, 5'b00000, 2'b11);
endtask

task automatic raw_hazard_stall();
  logic [31:0] val;
  run_one(i_type(12'd5, 5'd1, `DE_F3_ADD, 5'd6, `DE_OP_IMM), decode_pkg::iop_addi,
          32'd5, 5'b00001, 2'b10);  // producer decoded and retired once
  // repeat the producer, this time left in flight
  drive_fetch(i_type(12'd5, 5'd1, `DE_F3_ADD, 5'd6, `DE_OP_IMM));
  pc = pc + 32'd4;
  tick();
  compare("de_out.wr_reg", 32'd1, 32'(de_out.wr_reg));
  drive_fetch(r_type(`DE_F7_BASE, 5'd2, 5'd6, `DE_F3_ADD, 5'd7));  // reads x6
  repeat (3) begin
    #1;
    compare("stall", 32'd1, 32'(stall));
    tick();
    compare("de_out.valid", 32'd0, 32'(de_out.valid));
    compare("de_out.inst", 32'd0, de_out.inst);
  end
  val       = lfsr_bits(32);
  wb.wr_reg = 1'b1;
  wb.wregno = 5'd6;
  wb.regval = val;
  #1;
  compare("stall", 32'd0, 32'(stall));
  tick();
  wb       = '0;
  fe.valid = 1'b0;
  reg_model[6] = val;
  compare("de_out.valid", 32'd1, 32'(de_out.valid));
  compare("de_out.op", 32'(decode_pkg::iop_add), 32'(de_out.op));
  compare("de_out.rs1_val", val, de_out.rs1_val);
  compare("de_out.rs2_val", reg_model[2], de_out.rs2_val);
  retire(5'd7, lfsr_bits(32));
endtask

task automatic mispredict_flush();
  drive_fetch(r_type(`DE_F7_BASE, 5'd2, 5'd1, `DE_F3_OR, 5'd8));
  br_mispred = 1'b1;
  repeat (3) begin
    #1;
    compare("stall", 32'd1, 32'(stall));
    tick();
    compare("de_out.valid", 32'd0, 32'(de_out.valid));
    compare("de_out.inst", 32'd0, de_out.inst);
  end
  br_mispred = 1'b0;
  #1;
  compare("stall", 32'd0, 32'(stall));
  tick();
  fe.valid = 1'b0;
  compare("de_out.valid", 32'd1, 32'(de_out.valid));
  compare("de_out.op", 32'(decode_pkg::iop_or), 32'(de_out.op));
  compare("de_out.rs1_val", reg_model[1], de_out.rs1_val);
  compare("de_out.rs2_val", reg_model[2], de_out.rs2_val);
  retire(5'd8, lfsr_bits(32));
endtask

`endif

//--- sim/tb_decode_stage.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module tb_decode_stage;

  localparam int clk_half  = 10;  // 20 ns period
  localparam int drive_dly = 2;   // inputs change this long after the rising edge
  // reset 4, reset check 1, preload 8, alu 21, immediates 14, raw 8, flush 5
  localparam int test_cycles = 61;
  localparam int max_cycles  = 2 * test_cycles;

  logic                   clk;
  logic                   reset;
  decode_pkg::fetch_pkt_t fe;
  decode_pkg::wb_pkt_t    wb;
  logic                   br_mispred;
  logic                   stall;
  decode_pkg::de_latch_t  de_out;

  logic [15:0] lfsr_state;
  logic [31:0] reg_model [32];  // expected architectural register contents
  logic [31:0] pc;
  int          error_count;
  int          check_count;
  int          cycle_count;

  decode_stage uut (
    .clk        (clk),
    .reset      (reset),
    .fe         (fe),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall),
    .de_out     (de_out)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11, one step per bit taken
  function logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #drive_dly;
  endtask

  task automatic drive_fetch(input logic [31:0] inst);
    fe.valid    = 1'b1;
    fe.inst     = inst;
    fe.pc       = pc;
    fe.pc_plus4 = pc + 32'd4;
  endtask

  // one writeback cycle, fetch idle
  task automatic retire(input logic [4:0] rd, input logic [31:0] val);
    fe.valid  = 1'b0;
    wb.wr_reg = 1'b1;
    wb.wregno = rd;
    wb.regval = val;
    tick();
    wb = '0;
    reg_model[rd] = val;
  endtask

  `include "tb_decode_tasks.svh"

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", max_cycles);
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    fe          = '0;
    wb          = '0;
    br_mispred  = 1'b0;
    lfsr_state  = 16'd6035;
    pc          = 32'h0000_1000;
    error_count = 0;
    check_count = 0;
    for (int r = 0; r < 32; r++)
      reg_model[r] = '0;
    repeat (4) @(posedge clk);
    #drive_dly;
    reset = 1'b0;

    check_reset_state();
    decode_alu_ops();
    decode_imm_ctrl();
    raw_hazard_stall();
    mispredict_flush();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
+incdir+sim
hw/decode_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/hazard_scoreboard.sv
hw/decode_stage.sv
sim/tb_decode_stage.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_decode_stage
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
